/* src/blimp_pkg.sv */
//-----------------------------
// Blimp shared definitions
// Memory message formats and the decoded-instruction record
//-----------------------------

package blimp_pkg;

  //-----------------------------
  // Memory messages
  //-----------------------------

  // Opaque tag width, bit 0 holds the fetch epoch
  localparam int OPAQ_BITS = 8;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_type_e;

  // Request, 73 bits
  typedef struct packed {
    mem_type_e            mtype;
    logic [OPAQ_BITS-1:0] opaque;
    logic [31:0]          addr;
    logic [31:0]          data;
  } mem_req_t;

  // Response, 41 bits
  typedef struct packed {
    mem_type_e            mtype;
    logic [OPAQ_BITS-1:0] opaque;
    logic [31:0]          data;
  } mem_resp_t;

  //-----------------------------
  // Decode
  //-----------------------------

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  typedef enum logic [3:0] {
    KIND_ALU     = 4'd0,
    KIND_ALU_IMM = 4'd1,
    KIND_LUI     = 4'd2,
    KIND_LOAD    = 4'd3,
    KIND_STORE   = 4'd4,
    KIND_BEQ     = 4'd5,
    KIND_BNE     = 4'd6,
    KIND_JAL     = 4'd7,
    KIND_ILLEGAL = 4'd8
  } inst_kind_e;

  // One decoded instruction, 55 bits
  typedef struct packed {
    inst_kind_e  kind;
    alu_op_e     alu_op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        wen;
  } decoded_t;

endpackage

/* src/mem_intf.sv */
//-----------------------------
// Memory channel
// Val/rdy request and response pair
//-----------------------------

`timescale 1ns/1ns

interface mem_intf;

  // Request side
  logic                 req_val;
  logic                 req_rdy;
  blimp_pkg::mem_req_t  req_msg;

  // Response side, same order as requests
  logic                 resp_val;
  logic                 resp_rdy;
  blimp_pkg::mem_resp_t resp_msg;

  modport requester (
    output req_val, req_msg, resp_rdy,
    input  req_rdy, resp_val, resp_msg
  );

  modport server (
    input  req_val, req_msg, resp_rdy,
    output req_rdy, resp_val, resp_msg
  );

endinterface

/* src/fetch_intf.sv */
//-----------------------------
// Fetch to execute hand-off
// Instruction stream plus redirect back
//-----------------------------

`timescale 1ns/1ns

interface fetch_intf;

  logic        inst_val;
  logic        inst_rdy;
  logic [31:0] inst_pc;
  logic [31:0] inst_bits;

  // One-cycle pulse from execute
  logic        redirect;
  logic [31:0] redirect_pc;

  modport fetch (
    output inst_val, inst_pc, inst_bits,
    input  inst_rdy, redirect, redirect_pc
  );

  modport exec (
    input  inst_val, inst_pc, inst_bits,
    output inst_rdy, redirect, redirect_pc
  );

endinterface

/* src/blimp_decode.sv */
//-----------------------------
// Blimp decoder
// RV32I subset, class, ALU op and immediate
//-----------------------------

`timescale 1ns/1ns

module blimp_decode (
  input  logic [31:0]         inst_bits,
  output blimp_pkg::decoded_t dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = inst_bits[6:0];
  assign funct3 = inst_bits[14:12];
  assign funct7 = inst_bits[31:25];

  // Immediate formats
  assign imm_i = {{20{inst_bits[31]}}, inst_bits[31:20]};
  assign imm_s = {{20{inst_bits[31]}}, inst_bits[31:25], inst_bits[11:7]};
  assign imm_b = {{19{inst_bits[31]}}, inst_bits[31], inst_bits[7],
                  inst_bits[30:25], inst_bits[11:8], 1'b0};
  assign imm_u = {inst_bits[31:12], 12'b0};
  assign imm_j = {{11{inst_bits[31]}}, inst_bits[31], inst_bits[19:12],
                  inst_bits[20], inst_bits[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.kind   = blimp_pkg::KIND_ILLEGAL;
    dec.alu_op = blimp_pkg::ALU_ADD;
    dec.rd     = inst_bits[11:7];
    dec.rs1    = inst_bits[19:15];
    dec.rs2    = inst_bits[24:20];
    case (opcode)
      7'b0110011: begin
        if (funct7 == 7'b0000000) begin
          dec.kind = blimp_pkg::KIND_ALU;
          case (funct3)
            3'b000:  dec.alu_op = blimp_pkg::ALU_ADD;
            3'b111:  dec.alu_op = blimp_pkg::ALU_AND;
            3'b110:  dec.alu_op = blimp_pkg::ALU_OR;
            3'b100:  dec.alu_op = blimp_pkg::ALU_XOR;
            3'b010:  dec.alu_op = blimp_pkg::ALU_SLT;
            default: dec.kind   = blimp_pkg::KIND_ILLEGAL;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.kind   = blimp_pkg::KIND_ALU;
          dec.alu_op = blimp_pkg::ALU_SUB;
        end
      end
      // addi only
      7'b0010011: if (funct3 == 3'b000) begin
        dec.kind = blimp_pkg::KIND_ALU_IMM;
        dec.imm  = imm_i;
      end
      7'b0110111: begin
        dec.kind   = blimp_pkg::KIND_LUI;
        dec.alu_op = blimp_pkg::ALU_PASS_B;
        dec.imm    = imm_u;
      end
      // Word accesses only, address via ALU add
      7'b0000011: if (funct3 == 3'b010) begin
        dec.kind = blimp_pkg::KIND_LOAD;
        dec.imm  = imm_i;
      end
      7'b0100011: if (funct3 == 3'b010) begin
        dec.kind = blimp_pkg::KIND_STORE;
        dec.imm  = imm_s;
      end
      7'b1100011: begin
        dec.imm = imm_b;
        if (funct3 == 3'b000)
          dec.kind = blimp_pkg::KIND_BEQ;
        else if (funct3 == 3'b001)
          dec.kind = blimp_pkg::KIND_BNE;
      end
      7'b1101111: begin
        dec.kind = blimp_pkg::KIND_JAL;
        dec.imm  = imm_j;
      end
      default: dec.kind = blimp_pkg::KIND_ILLEGAL;
    endcase
    // Writers only, and never x0
    dec.wen = (dec.kind == blimp_pkg::KIND_ALU || dec.kind == blimp_pkg::KIND_ALU_IMM ||
               dec.kind == blimp_pkg::KIND_LUI || dec.kind == blimp_pkg::KIND_LOAD ||
               dec.kind == blimp_pkg::KIND_JAL) && (dec.rd != 5'd0);
  end

endmodule

/* src/blimp_regfile.sv */
//-----------------------------
// Blimp register file
// 31 x 32 bits, 2 read ports, 1 write port
//-----------------------------

`timescale 1ns/1ns

module blimp_regfile (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  // No storage for x0
  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (wen && waddr != 5'd0)
      regs[waddr] <= wdata;
  end

  // Combinational reads, x0 reads zero
  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* src/blimp_fetch.sv */
//-----------------------------
// Blimp fetch unit
// PC generation, in-flight tracking, epoch squash
//-----------------------------

`timescale 1ns/1ns

module blimp_fetch #(
  parameter logic [31:0] p_reset_pc    = 32'h0,
  parameter int          p_fetch_depth = 2
) (
  input logic        clk,
  input logic        rst,
  mem_intf.requester imem,
  fetch_intf.fetch   fe
);

  //-----------------------------
  // State
  //-----------------------------

  // Next address to request
  logic [31:0] pc;
  // PC of the next current-epoch response
  logic [31:0] resp_pc;
  logic        epoch;

  // Held request
  logic        req_val_r;
  logic [31:0] req_addr;
  logic        req_epoch;

  // Requests sent but not yet answered
  logic [1:0]  outst;

  // Two-entry instruction buffer
  logic [31:0] buf_pc   [2];
  logic [31:0] buf_bits [2];
  logic        head;
  logic        tail;
  logic [1:0]  occ;

  logic        req_fire;
  logic        resp_fire;
  logic        push;
  logic        pop;
  logic        load_req;
  logic [2:0]  used;

  assign req_fire  = imem.req_val && imem.req_rdy;
  assign resp_fire = imem.resp_val && imem.resp_rdy;

  // Keep only responses of the live epoch, and none while redirecting
  assign push = resp_fire && (imem.resp_msg.opaque[0] == epoch) && !fe.redirect;
  assign pop  = fe.inst_val && fe.inst_rdy;

  // Slots taken: in flight, buffered, or waiting to be sent
  assign used = {1'b0, outst} + {1'b0, occ} + {2'b00, req_val_r};

  // New request once the held one leaves and a slot is free
  assign load_req = (!req_val_r || req_fire) && (used < 3'(p_fetch_depth))
                    && !fe.redirect;

  //-----------------------------
  // PC, epoch and request
  //-----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= p_reset_pc;
      resp_pc   <= p_reset_pc;
      epoch     <= 1'b0;
      req_val_r <= 1'b0;
      outst     <= 2'd0;
    end else begin
      if (load_req) begin
        req_val_r <= 1'b1;
        pc        <= pc + 32'd4;
      end else if (req_fire) begin
        req_val_r <= 1'b0;
      end
      // Redirect wins over sequential PC
      if (fe.redirect) begin
        pc      <= fe.redirect_pc;
        resp_pc <= fe.redirect_pc;
        epoch   <= ~epoch;
      end else if (push) begin
        resp_pc <= resp_pc + 32'd4;
      end
      // Stale responses still drain the counter
      outst <= outst + 2'(req_fire) - 2'(resp_fire);
    end
  end

  always_ff @(posedge clk) begin
    if (load_req) begin
      req_addr  <= pc;
      req_epoch <= epoch;
    end
  end

  //-----------------------------
  // Instruction buffer
  //-----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= 1'b0;
      tail <= 1'b0;
      occ  <= 2'd0;
    end else if (fe.redirect) begin
      // Flush wrong-path entries
      head <= 1'b0;
      tail <= 1'b0;
      occ  <= 2'd0;
    end else begin
      if (push)
        tail <= ~tail;
      if (pop)
        head <= ~head;
      occ <= occ + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_pc[tail]   <= resp_pc;
      buf_bits[tail] <= imem.resp_msg.data;
    end
  end

  //-----------------------------
  // Outputs
  //-----------------------------

  always_comb begin
    imem.req_msg           = '0;
    imem.req_msg.mtype     = blimp_pkg::MEM_READ;
    // Epoch tag in opaque bit 0
    imem.req_msg.opaque[0] = req_epoch;
    imem.req_msg.addr      = req_addr;
  end

  assign imem.req_val  = req_val_r;
  // Room is reserved by the slot count, full only with nothing in flight
  assign imem.resp_rdy = (occ != 2'd2);

  assign fe.inst_val  = (occ != 2'd0) && !fe.redirect;
  assign fe.inst_pc   = buf_pc[head];
  assign fe.inst_bits = buf_bits[head];

endmodule

/* src/blimp_exec.sv */
//-----------------------------
// Blimp execute unit
// Decode, ALU, data access, branch and write-back
//-----------------------------

`timescale 1ns/1ns

module blimp_exec (
  input  logic        clk,
  input  logic        rst,
  fetch_intf.exec     fe,
  mem_intf.requester  dmem,
  output logic        trace_val,
  output logic [31:0] trace_pc,
  output logic [4:0]  trace_waddr,
  output logic [31:0] trace_wdata,
  output logic        trace_wen
);

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_EXEC = 2'd1,
    S_WAIT = 2'd2
  } state_e;

  state_e              state;
  blimp_pkg::decoded_t dec;
  blimp_pkg::decoded_t dec_r;

  logic [31:0] pc_r;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] alu_b;
  logic [31:0] alu_out;
  logic [31:0] wb_data;
  logic [31:0] ld_data;
  logic [31:0] target;
  logic        mem_done;
  logic        is_mem;
  logic        is_load;
  logic        taken;
  logic        retire;
  logic        accept;
  logic        req_fire;
  logic        resp_fire;

  //-----------------------------
  // Decode and registers
  //-----------------------------

  blimp_decode decode_inst (
    .inst_bits (fe.inst_bits),
    .dec       (dec)
  );

  // Reads use the latched instruction
  blimp_regfile regfile_inst (
    .clk    (clk),
    .rs1    (dec_r.rs1),
    .rs2    (dec_r.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (retire && dec_r.wen),
    .waddr  (dec_r.rd),
    .wdata  (wb_data)
  );

  assign accept    = fe.inst_val && fe.inst_rdy;
  assign req_fire  = dmem.req_val && dmem.req_rdy;
  assign resp_fire = dmem.resp_val && dmem.resp_rdy;

  assign is_load = (dec_r.kind == blimp_pkg::KIND_LOAD);
  assign is_mem  = is_load || (dec_r.kind == blimp_pkg::KIND_STORE);

  // Memory ops retire once their response is back
  assign retire = (state == S_EXEC) && (!is_mem || mem_done);

  //-----------------------------
  // Control FSM
  //-----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      mem_done <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (accept) begin
          state    <= S_EXEC;
          mem_done <= 1'b0;
        end
        S_EXEC: begin
          if (retire)
            state <= S_IDLE;
          else if (req_fire)
            state <= S_WAIT;
        end
        S_WAIT: if (resp_fire) begin
          // Back to execute for the retire cycle
          state    <= S_EXEC;
          mem_done <= 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_r  <= fe.inst_pc;
      dec_r <= dec;
    end
    if (resp_fire)
      ld_data <= dmem.resp_msg.data;
  end

  //-----------------------------
  // Datapath
  //-----------------------------

  assign alu_b = (dec_r.kind == blimp_pkg::KIND_ALU) ? rdata2 : dec_r.imm;

  always_comb begin
    case (dec_r.alu_op)
      blimp_pkg::ALU_SUB:    alu_out = rdata1 - alu_b;
      blimp_pkg::ALU_AND:    alu_out = rdata1 & alu_b;
      blimp_pkg::ALU_OR:     alu_out = rdata1 | alu_b;
      blimp_pkg::ALU_XOR:    alu_out = rdata1 ^ alu_b;
      blimp_pkg::ALU_SLT:    alu_out = {31'd0, $signed(rdata1) < $signed(alu_b)};
      blimp_pkg::ALU_PASS_B: alu_out = alu_b;
      default:               alu_out = rdata1 + alu_b;
    endcase
  end

  // Link value for jal, loaded word for lw
  always_comb begin
    case (dec_r.kind)
      blimp_pkg::KIND_LOAD: wb_data = ld_data;
      blimp_pkg::KIND_JAL:  wb_data = pc_r + 32'd4;
      default:              wb_data = alu_out;
    endcase
  end

  // Branch resolution
  assign target = pc_r + dec_r.imm;
  assign taken  = (dec_r.kind == blimp_pkg::KIND_JAL) ||
                  (dec_r.kind == blimp_pkg::KIND_BEQ && rdata1 == rdata2) ||
                  (dec_r.kind == blimp_pkg::KIND_BNE && rdata1 != rdata2);

  //-----------------------------
  // Ports
  //-----------------------------

  assign fe.inst_rdy    = (state == S_IDLE);
  assign fe.redirect    = retire && taken;
  assign fe.redirect_pc = target;

  // Address is rs1 + imm from the ALU
  always_comb begin
    dmem.req_msg        = '0;
    dmem.req_msg.mtype  = is_load ? blimp_pkg::MEM_READ : blimp_pkg::MEM_WRITE;
    dmem.req_msg.addr   = alu_out;
    dmem.req_msg.data   = rdata2;
  end

  assign dmem.req_val  = (state == S_EXEC) && is_mem && !mem_done;
  assign dmem.resp_rdy = (state == S_WAIT);

  // One pulse per retired instruction
  assign trace_val   = retire;
  assign trace_pc    = pc_r;
  assign trace_waddr = dec_r.rd;
  assign trace_wdata = wb_data;
  assign trace_wen   = dec_r.wen;

endmodule

/* src/blimp_top.sv */
//-----------------------------
// Blimp processor top
// Fetch and execute on split memory ports
//-----------------------------

`timescale 1ns/1ns

module blimp_top #(
  parameter logic [31:0] p_reset_pc    = 32'h0,
  parameter int          p_fetch_depth = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  // Instruction memory
  output logic                 imem_req_val,
  input  logic                 imem_req_rdy,
  output blimp_pkg::mem_req_t  imem_req_msg,
  input  logic                 imem_resp_val,
  output logic                 imem_resp_rdy,
  input  blimp_pkg::mem_resp_t imem_resp_msg,
  // Data memory
  output logic                 dmem_req_val,
  input  logic                 dmem_req_rdy,
  output blimp_pkg::mem_req_t  dmem_req_msg,
  input  logic                 dmem_resp_val,
  output logic                 dmem_resp_rdy,
  input  blimp_pkg::mem_resp_t dmem_resp_msg,
  // Retirement trace
  output logic                 trace_val,
  output logic [31:0]          trace_pc,
  output logic [4:0]           trace_waddr,
  output logic [31:0]          trace_wdata,
  output logic                 trace_wen
);

  mem_intf   imem_if ();
  mem_intf   dmem_if ();
  fetch_intf fe_if   ();

  // Port mapping
  assign imem_req_val      = imem_if.req_val;
  assign imem_req_msg      = imem_if.req_msg;
  assign imem_resp_rdy     = imem_if.resp_rdy;
  assign imem_if.req_rdy   = imem_req_rdy;
  assign imem_if.resp_val  = imem_resp_val;
  assign imem_if.resp_msg  = imem_resp_msg;

  assign dmem_req_val      = dmem_if.req_val;
  assign dmem_req_msg      = dmem_if.req_msg;
  assign dmem_resp_rdy     = dmem_if.resp_rdy;
  assign dmem_if.req_rdy   = dmem_req_rdy;
  assign dmem_if.resp_val  = dmem_resp_val;
  assign dmem_if.resp_msg  = dmem_resp_msg;

  blimp_fetch #(
    .p_reset_pc    (p_reset_pc),
    .p_fetch_depth (p_fetch_depth)
  ) fetch_inst (
    .clk  (clk),
    .rst  (rst),
    .imem (imem_if.requester),
    .fe   (fe_if.fetch)
  );

  blimp_exec exec_inst (
    .clk         (clk),
    .rst         (rst),
    .fe          (fe_if.exec),
    .dmem        (dmem_if.requester),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

endmodule

/* testbench/blimp_tb_sva.sv */
//-----------------------------
// Blimp handshake and trace checks
// Bound to the processor top
//-----------------------------

`timescale 1ns/1ns

module blimp_tb_sva (
  input logic                clk,
  input logic                rst,
  input logic                imem_req_val,
  input logic                imem_req_rdy,
  input blimp_pkg::mem_req_t imem_req_msg,
  input logic                dmem_req_val,
  input logic                dmem_req_rdy,
  input blimp_pkg::mem_req_t dmem_req_msg,
  input logic                dmem_resp_val,
  input logic                dmem_resp_rdy,
  input logic                trace_val,
  input logic [31:0]         trace_pc
);

  // Reset seen on an earlier edge, state is known from then on
  logic past_rst = 1'b0;
  // Data request sent, response not yet back
  logic dmem_pend;

  always @(posedge clk) begin
    past_rst <= rst;
    if (rst)
      dmem_pend <= 1'b0;
    else if (dmem_req_val && dmem_req_rdy)
      dmem_pend <= 1'b1;
    else if (dmem_resp_val && dmem_resp_rdy)
      dmem_pend <= 1'b0;
  end

  // Held request stays put until taken
  imem_hold: assert property (@(posedge clk) disable iff (rst)
    imem_req_val && !imem_req_rdy |=> imem_req_val && $stable(imem_req_msg))
    else $error("imem request dropped or changed before rdy");

  dmem_hold: assert property (@(posedge clk) disable iff (rst)
    dmem_req_val && !dmem_req_rdy |=> dmem_req_val && $stable(dmem_req_msg))
    else $error("dmem request dropped or changed before rdy");

  trace_in_reset: assert property (@(posedge clk) past_rst && rst |-> !trace_val)
    else $error("trace pulse during reset");

  trace_aligned: assert property (@(posedge clk) disable iff (rst)
    trace_val |-> trace_pc[1:0] == 2'b00)
    else $error("trace pc not word aligned");

  dmem_one_out: assert property (@(posedge clk) disable iff (rst)
    dmem_pend |-> !dmem_req_val)
    else $error("dmem request while a response is pending");

endmodule

bind blimp_top blimp_tb_sva sva_inst (.*);

/* testbench/blimp_tb.sv */
//-----------------------------
// Blimp processor testbench
// Memory model with random delays, ISA reference model
// and trace compare
//-----------------------------

`timescale 1ns/1ns

module blimp_tb;

  localparam int MEM_WORDS = 256;
  // 20 setup instructions, then 8 passes of 27 over the main loop
  localparam int N_RETIRE  = 20 + 27 * 8;
  localparam int TIMEOUT   = 40 * N_RETIRE + 200;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } trace_t;

  logic clk;
  logic rst;
  // Index 0 is imem, 1 is dmem
  logic                 req_rdy  [2];
  logic                 resp_val [2];
  blimp_pkg::mem_resp_t resp_msg [2];

  logic                 imem_req_val, imem_resp_rdy, dmem_req_val, dmem_resp_rdy;
  blimp_pkg::mem_req_t  imem_req_msg, dmem_req_msg;
  logic                 trace_val, trace_wen;
  logic [31:0]          trace_pc, trace_wdata;
  logic [4:0]           trace_waddr;

  // DUT memory and the model's own copy
  logic [31:0] mem       [MEM_WORDS];
  logic [31:0] model_mem [MEM_WORDS];
  logic [31:0] model_reg [32];
  logic [31:0] model_pc;

  // Per-port response buffers, in request order
  blimp_pkg::mem_resp_t rq [2][8];
  int rq_head [2];
  int rq_cnt  [2];
  int delay   [2];

  logic [31:0] lcg_state = 32'd20843;
  int          retired   = 0;
  int          cycles    = 0;
  // Second half of the run, set one edge after the count
  logic        heavy     = 1'b0;

  blimp_top blimp_top_inst (
    .clk           (clk),
    .rst           (rst),
    .imem_req_val  (imem_req_val),
    .imem_req_rdy  (req_rdy[0]),
    .imem_req_msg  (imem_req_msg),
    .imem_resp_val (resp_val[0]),
    .imem_resp_rdy (imem_resp_rdy),
    .imem_resp_msg (resp_msg[0]),
    .dmem_req_val  (dmem_req_val),
    .dmem_req_rdy  (req_rdy[1]),
    .dmem_req_msg  (dmem_req_msg),
    .dmem_resp_val (resp_val[1]),
    .dmem_resp_rdy (dmem_resp_rdy),
    .dmem_resp_msg (resp_msg[1]),
    .trace_val     (trace_val),
    .trace_pc      (trace_pc),
    .trace_waddr   (trace_waddr),
    .trace_wdata   (trace_wdata),
    .trace_wen     (trace_wen)
  );

  //-----------------------------
  // Helpers
  //-----------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg_state[30:15]};
  endfunction

  task automatic fail_run();
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string test, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", test, exp, act);
      fail_run();
    end
  endtask

  task automatic check_reg(input string test, input logic [4:0] exp, input logic [4:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %0d actual %0d", test, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string test, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %b actual %b", test, exp, act);
      fail_run();
    end
  endtask

  // RV32 encoders for building the program
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  //-----------------------------
  // ISA reference model
  //-----------------------------

  function automatic trace_t model_step();
    trace_t      t;
    logic [31:0] inst, a, b, imm_i, imm_s, imm_b, imm_j, next_pc;
    logic [6:0]  op, f7;
    logic [2:0]  f3;
    inst    = model_mem[model_pc[9:2]];
    op      = inst[6:0];
    f3      = inst[14:12];
    f7      = inst[31:25];
    a       = model_reg[inst[19:15]];
    b       = model_reg[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    t.pc    = model_pc;
    t.waddr = inst[11:7];
    t.wdata = 32'd0;
    t.wen   = 1'b0;
    next_pc = model_pc + 32'd4;
    case (op)
      7'h33: begin
        t.wen = 1'b1;
        if (f7 == 7'h00 && f3 == 3'd0) t.wdata = a + b;
        else if (f7 == 7'h20 && f3 == 3'd0) t.wdata = a - b;
        else if (f7 == 7'h00 && f3 == 3'd7) t.wdata = a & b;
        else if (f7 == 7'h00 && f3 == 3'd6) t.wdata = a | b;
        else if (f7 == 7'h00 && f3 == 3'd4) t.wdata = a ^ b;
        else if (f7 == 7'h00 && f3 == 3'd2) t.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else t.wen = 1'b0;
      end
      7'h13: if (f3 == 3'd0) begin
        t.wen   = 1'b1;
        t.wdata = a + imm_i;
      end
      7'h37: begin
        t.wen   = 1'b1;
        t.wdata = {inst[31:12], 12'd0};
      end
      7'h03: if (f3 == 3'd2) begin
        t.wen   = 1'b1;
        t.wdata = model_mem[(a + imm_i) >> 2];
      end
      7'h23: if (f3 == 3'd2) model_mem[(a + imm_s) >> 2] = b;
      7'h63: begin
        if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b))
          next_pc = model_pc + imm_b;
      end
      7'h6f: begin
        t.wen   = 1'b1;
        t.wdata = model_pc + 32'd4;
        next_pc = model_pc + imm_j;
      end
      default: t.wen = 1'b0;
    endcase
    // x0 never changes
    if (t.wen && t.waddr != 5'd0)
      model_reg[t.waddr] = t.wdata;
    else
      t.wen = 1'b0;
    model_pc = next_pc;
    return t;
  endfunction

  function automatic string test_name(logic [31:0] pc);
    if (pc < 32'd44) return "alu_imm_seq";
    if (pc < 32'd56) return "x0_writes";
    if (pc < 32'd72) return "illegal";
    if (heavy) return "backpressure";
    if (pc < 32'd112) return "store_load";
    return "branch_jal";
  endfunction

  task automatic put_word(input int idx, input logic [31:0] w);
    mem[idx]       = w;
    model_mem[idx] = w;
  endtask

  //-----------------------------
  // Clock, reset, program
  //-----------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req_rdy[p]  = 1'b0;
      resp_val[p] = 1'b0;
      resp_msg[p] = '0;
    end
    // Fill depends on the whole byte address
    for (int i = 0; i < MEM_WORDS; i++)
      put_word(i, 32'h3c5a_0000 ^ (i * 4));
    for (int r = 0; r < 32; r++)
      model_reg[r] = 32'd0;
    model_pc = 32'd0;
    // ALU and immediates
    put_word(0,  enc_i(5, 0, 0, 1, 7'h13));
    put_word(1,  enc_i(-3, 0, 0, 2, 7'h13));
    put_word(2,  enc_r(7'h00, 2, 1, 0, 3));
    put_word(3,  enc_r(7'h20, 2, 1, 0, 4));
    put_word(4,  enc_r(7'h00, 2, 1, 7, 5));
    put_word(5,  enc_r(7'h00, 2, 1, 6, 6));
    put_word(6,  enc_r(7'h00, 2, 1, 4, 7));
    put_word(7,  enc_r(7'h00, 1, 2, 2, 8));
    put_word(8,  enc_r(7'h00, 2, 1, 2, 9));
    put_word(9,  {20'h12345, 5'd10, 7'h37});
    put_word(10, enc_i(32'h678, 10, 0, 10, 7'h13));
    // Writes to x0, then reads of x0
    put_word(11, enc_i(7, 1, 0, 0, 7'h13));
    put_word(12, {20'habcde, 5'd0, 7'h37});
    put_word(13, enc_r(7'h00, 1, 0, 0, 11));
    // Illegal encodings must leave x12 alone
    put_word(14, enc_i(77, 0, 0, 12, 7'h13));
    put_word(15, enc_r(7'h01, 2, 1, 0, 12));
    put_word(16, 32'hffff_ffff);
    put_word(17, enc_r(7'h00, 0, 12, 0, 13));
    put_word(18, enc_i(32'h200, 0, 0, 20, 7'h13));
    put_word(19, enc_i(0, 0, 0, 22, 7'h13));
    // Main pass, stores then loads
    put_word(20, enc_s(0, 10, 20));
    put_word(21, enc_s(4, 4, 20));
    put_word(22, enc_i(0, 20, 2, 14, 7'h03));
    put_word(23, enc_i(4, 20, 2, 15, 7'h03));
    put_word(24, enc_r(7'h00, 15, 14, 0, 16));
    put_word(25, enc_s(8, 16, 20));
    put_word(26, enc_i(8, 20, 2, 17, 7'h03));
    put_word(27, enc_i(3, 0, 0, 21, 7'h13));
    // Counted bne loop
    put_word(28, enc_r(7'h00, 21, 22, 0, 22));
    put_word(29, enc_s(12, 22, 20));
    put_word(30, enc_i(-1, 21, 0, 21, 7'h13));
    put_word(31, enc_b(-12, 0, 21, 1));
    // Taken beq over a wrong-path addi
    put_word(32, enc_b(8, 0, 21, 0));
    put_word(33, enc_i(99, 0, 0, 23, 7'h13));
    put_word(34, enc_b(8, 2, 1, 0));
    put_word(35, enc_b(8, 1, 1, 1));
    put_word(36, enc_j(8, 24));
    put_word(37, enc_i(98, 0, 0, 23, 7'h13));
    put_word(38, enc_i(12, 20, 2, 25, 7'h03));
    put_word(39, enc_r(7'h00, 24, 25, 0, 26));
    // Back to the start of the pass
    put_word(40, enc_j(-80, 0));
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

  //-----------------------------
  // Memory model, both ports
  //-----------------------------

  always @(posedge clk) begin
    blimp_pkg::mem_req_t  req;
    blimp_pkg::mem_resp_t rsp;
    logic                 v;
    logic                 rr;
    if (rst) begin
      for (int p = 0; p < 2; p++) begin
        req_rdy[p]  <= 1'b0;
        resp_val[p] <= 1'b0;
        rq_head[p]  = 0;
        rq_cnt[p]   = 0;
        delay[p]    = 0;
      end
    end else begin
      for (int p = 0; p < 2; p++) begin
        v   = (p == 0) ? imem_req_val : dmem_req_val;
        req = (p == 0) ? imem_req_msg : dmem_req_msg;
        rr  = (p == 0) ? imem_resp_rdy : dmem_resp_rdy;
        // Head response taken, pick the gap before the next
        if (resp_val[p] && rr) begin
          rq_head[p] = (rq_head[p] + 1) % 8;
          rq_cnt[p]--;
          delay[p]   = heavy ? lcg_next() % 8 : lcg_next() % 3;
        end
        if (v && req_rdy[p]) begin
          if (rq_cnt[p] == 8) begin
            $display("memory port %0d has more than 8 requests outstanding", p);
            fail_run();
          end
          rsp.mtype  = req.mtype;
          rsp.opaque = req.opaque;
          rsp.data   = mem[req.addr[9:2]];
          if (req.mtype == blimp_pkg::MEM_WRITE) begin
            mem[req.addr[9:2]] = req.data;
            rsp.data           = 32'd0;
          end
          rq[p][(rq_head[p] + rq_cnt[p]) % 8] = rsp;
          rq_cnt[p]++;
        end
        if (delay[p] > 0)
          delay[p]--;
        resp_val[p] <= (rq_cnt[p] > 0) && (delay[p] == 0);
        resp_msg[p] <= rq[p][rq_head[p]];
        // Mostly ready early on, mostly stalled in the second half
        req_rdy[p]  <= heavy ? (lcg_next() % 4 == 0) : (lcg_next() % 4 != 0);
      end
    end
  end

  //-----------------------------
  // Trace compare
  //-----------------------------

  always @(posedge clk) begin
    trace_t exp;
    string  name;
    if (!rst && trace_val) begin
      exp  = model_step();
      name = $sformatf("%s #%0d", test_name(exp.pc), retired);
      check_word({name, " pc"}, exp.pc, trace_pc);
      check_bit({name, " wen"}, exp.wen, trace_wen);
      if (exp.wen) begin
        check_reg({name, " waddr"}, exp.waddr, trace_waddr);
        check_word({name, " wdata"}, exp.wdata, trace_wdata);
      end
      retired++;
      heavy <= (retired >= N_RETIRE / 2);
      if (retired == N_RETIRE) begin
        for (int i = 0; i < MEM_WORDS; i++)
          check_word($sformatf("final_memory word %0d", i), model_mem[i], mem[i]);
        $display("** PASS **");
        $finish;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("timeout after %0d cycles with %0d of %0d instructions retired",
               cycles, retired, N_RETIRE);
      fail_run();
    end
  end

endmodule

/* sources.f */
src/blimp_pkg.sv
src/mem_intf.sv
src/fetch_intf.sv
src/blimp_decode.sv
src/blimp_regfile.sv
src/blimp_fetch.sv
src/blimp_exec.sv
src/blimp_top.sv
testbench/blimp_tb_sva.sv
testbench/blimp_tb.sv
